/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tbCpu
RTL_TOP    ?= cpuTop
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+verif
hw/cpuPkg.sv
hw/wordMemory.sv
hw/programCounter.sv
hw/registerFile.sv
hw/accumulatorAlu.sv
hw/sequencer.sv
hw/hostPort.sv
hw/cpuTop.sv
verif/tbCpu.sv

/* hw/accumulatorAlu.sv */
`timescale 1ns/1ps

module accumulatorAlu (
  input  logic            clk,
  input  logic            RESET,
  input  cpuPkg::aluCtrlT ctrl,
  input  cpuPkg::dataT    operand,
  input  cpuPkg::dataT    memData,
  input  cpuPkg::dataT    inPort,
  output cpuPkg::dataT    acc,
  output cpuPkg::flagsT   flags,
  output cpuPkg::dataT    outPort
);
  import cpuPkg::*;

  logic [8:0] twoRes;
  logic       twoValid;
  dataT       oneRes;
  logic       oneValid;

  // bit 8 carries the add carry or the sub borrow
  always_comb
  begin
    twoValid = 1'b1;
    case (ctrl.func)
      FN_AND: twoRes = {1'b0, acc & operand};
      FN_XOR: twoRes = {1'b0, acc ^ operand};
      FN_OR:  twoRes = {1'b0, acc | operand};
      FN_ADD: twoRes = {1'b0, acc} + {1'b0, operand};
      FN_SUB: twoRes = {1'b0, acc} - {1'b0, operand};
      default:
      begin
        twoRes   = '0;
        twoValid = 1'b0;
      end
    endcase
  end

  always_comb
  begin
    oneValid = 1'b1;
    case (ctrl.func)
      FN_CMA: oneRes = ~acc;
      FN_INC: oneRes = acc + 8'd1;
      FN_DEC: oneRes = acc - 8'd1;
      FN_RR:  oneRes = {acc[0], acc[7:1]};
      FN_RL:  oneRes = {acc[6:0], acc[7]};
      default:
      begin
        oneRes   = acc;
        oneValid = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulator, flags and output port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (RESET)
    begin
      acc     <= '0;
      flags   <= '0;
      outPort <= '0;
    end
    else
    begin
      case (ctrl.op)
        OP_LOAD: acc <= (ctrl.func == LD_SRC_BUS) ? memData : operand;
        OP_TWO:
        begin
          if (twoValid)
          begin
            acc     <= twoRes[7:0];
            flags.z <= (twoRes[7:0] == 8'd0);
            flags.p <= ^twoRes[7:0];
            if (ctrl.func == FN_ADD)
              flags.c <= twoRes[8];
            if (ctrl.func == FN_SUB)
              flags.b <= twoRes[8];
          end
        end
        // flags stay as they were
        OP_ONE:
        begin
          if (oneValid)
            acc <= oneRes;
        end
        OP_IN:   acc     <= inPort;
        OP_OUT:  outPort <= acc;
        default: ;
      endcase
    end
  end

endmodule

/* hw/cpuPkg.sv */
package cpuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and base types
  ////////////////////////////////////////////////////////////////////////////

  localparam int APB_ADDR_W = 12;

  typedef logic [7:0] dataT;
  typedef logic [15:0] instrT;
  typedef logic [2:0] regIdxT;

  // instruction class, bits 15..14
  typedef enum logic [1:0] {
    CLS_DT,
    CLS_ALU,
    CLS_BR,
    CLS_MIO
  } instrClassT;

  typedef struct packed {
    logic z;
    logic c;
    logic b;
    logic p;
  } flagsT;

  // what the accumulator does this cycle
  typedef enum logic [2:0] {
    OP_NONE,
    OP_LOAD,
    OP_TWO,
    OP_ONE,
    OP_IN,
    OP_OUT
  } aluOpT;

  typedef struct packed {
    aluOpT      op;
    logic [2:0] func;
  } aluCtrlT;

  typedef struct packed {
    logic       en;
    logic       we;
    logic [7:0] addr;
    dataT       wdata;
  } dmReqT;

  ////////////////////////////////////////////////////////////////////////////
  // opcode field values
  ////////////////////////////////////////////////////////////////////////////

  // data transfer, bits 13..11
  localparam logic [2:0] DT_MOV_RA = 3'b000;
  localparam logic [2:0] DT_LDI    = 3'b001;
  localparam logic [2:0] DT_MOV_AR = 3'b010;
  localparam logic [2:0] DT_LDM    = 3'b100;
  localparam logic [2:0] DT_STM    = 3'b101;

  // alu group, bits 13..12
  localparam logic [1:0] ALU_GRP_TWO = 2'b00;
  localparam logic [1:0] ALU_GRP_ONE = 2'b01;

  // two-operand functions, bits 11..9
  localparam logic [2:0] FN_AND = 3'd0;
  localparam logic [2:0] FN_XOR = 3'd1;
  localparam logic [2:0] FN_OR  = 3'd2;
  localparam logic [2:0] FN_ADD = 3'd3;
  localparam logic [2:0] FN_SUB = 3'd4;

  // single-operand functions, bits 11..9
  localparam logic [2:0] FN_CMA = 3'd0;
  localparam logic [2:0] FN_INC = 3'd1;
  localparam logic [2:0] FN_DEC = 3'd2;
  localparam logic [2:0] FN_RR  = 3'd3;
  localparam logic [2:0] FN_RL  = 3'd4;

  // load source in aluCtrlT.func
  localparam logic [2:0] LD_SRC_REG = 3'd0;
  localparam logic [2:0] LD_SRC_BUS = 3'd1;

  // branch conditions, bits 13..11
  localparam logic [2:0] BR_ALWAYS = 3'd0;
  localparam logic [2:0] BR_Z      = 3'd1;
  localparam logic [2:0] BR_C      = 3'd2;
  localparam logic [2:0] BR_B      = 3'd3;
  localparam logic [2:0] BR_P      = 3'd4;

  // machine and io, bits 13..11
  localparam logic [2:0] MIO_HALT = 3'b000;
  localparam logic [2:0] MIO_IN   = 3'b100;
  localparam logic [2:0] MIO_OUT  = 3'b101;

endpackage

/* hw/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
  parameter int imAddrW = 8,
  parameter int dmAddrW = 8
) (
  input  logic                          clk,
  input  logic                          RESET,
  input  cpuPkg::dataT                  inPort,
  output cpuPkg::dataT                  outPort,
  input  logic                          PSEL,
  input  logic                          PENABLE,
  input  logic                          PWRITE,
  input  logic [cpuPkg::APB_ADDR_W-1:0] PADDR,
  input  logic [15:0]                   PWDATA,
  output logic [15:0]                   PRDATA,
  output logic                          PREADY,
  output logic                          PSLVERR
);
  import cpuPkg::*;

  logic                  start;
  logic                  running;
  logic                  fetch;
  logic                  pcInc;
  logic                  pcLoad;
  logic [imAddrW-1:0]    pc;
  instrT                 instr;
  flagsT                 flags;
  aluCtrlT               aluCtrl;
  dataT                  loadData;
  dataT                  acc;
  logic                  regWrite;
  regIdxT                regIdx;
  dataT                  regData;
  dmReqT                 coreDmReq;
  dmReqT                 dmReq;
  dataT                  dmRdata;
  logic                  imWe;
  logic [APB_ADDR_W-3:0] hostImAddr;
  instrT                 imWdata;
  logic                  imEn;
  logic [imAddrW-1:0]    imAddr;

  // core owns the instruction memory while running, the host while halted
  assign imEn   = fetch || imWe;
  assign imAddr = running ? pc : hostImAddr[imAddrW-1:0];

  sequencer u_sequencer (
    .clk      (clk),
    .RESET    (RESET),
    .start    (start),
    .running  (running),
    .instr    (instr),
    .flags    (flags),
    .acc      (acc),
    .fetch    (fetch),
    .pcInc    (pcInc),
    .pcLoad   (pcLoad),
    .aluCtrl  (aluCtrl),
    .loadData (loadData),
    .regWrite (regWrite),
    .regIdx   (regIdx),
    .dmReq    (coreDmReq),
    .dmRdata  (dmRdata)
  );

  programCounter #(.imAddrW(imAddrW)) u_programCounter (
    .clk    (clk),
    .RESET  (RESET),
    .clear  (start),
    .inc    (pcInc),
    .load   (pcLoad),
    .target (instr),
    .pc     (pc)
  );

  registerFile u_registerFile (
    .clk   (clk),
    .RESET (RESET),
    .we    (regWrite),
    .wIdx  (regIdx),
    .wData (acc),
    .rIdx  (regIdx),
    .rData (regData)
  );

  accumulatorAlu u_accumulatorAlu (
    .clk     (clk),
    .RESET   (RESET),
    .ctrl    (aluCtrl),
    .operand (regData),
    .memData (loadData),
    .inPort  (inPort),
    .acc     (acc),
    .flags   (flags),
    .outPort (outPort)
  );

  hostPort #(.dmAddrW(dmAddrW)) u_hostPort (
    .clk       (clk),
    .RESET     (RESET),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PRDATA    (PRDATA),
    .PREADY    (PREADY),
    .PSLVERR   (PSLVERR),
    .running   (running),
    .start     (start),
    .imWe      (imWe),
    .imAddr    (hostImAddr),
    .imWdata   (imWdata),
    .coreDmReq (coreDmReq),
    .dmReq     (dmReq),
    .dmRdata   (dmRdata)
  );

  wordMemory #(.wordT(instrT), .addrW(imAddrW)) u_instrMem (
    .clk   (clk),
    .en    (imEn),
    .we    (imWe),
    .addr  (imAddr),
    .wdata (imWdata),
    .rdata (instr)
  );

  wordMemory #(.wordT(dataT), .addrW(dmAddrW)) u_dataMem (
    .clk   (clk),
    .en    (dmReq.en),
    .we    (dmReq.we),
    .addr  (dmReq.addr[dmAddrW-1:0]),
    .wdata (dmReq.wdata),
    .rdata (dmRdata)
  );

endmodule

/* hw/hostPort.sv */
`timescale 1ns/1ps

module hostPort #(
  parameter int dmAddrW = 8
) (
  input  logic                          clk,
  input  logic                          RESET,
  input  logic                          PSEL,
  input  logic                          PENABLE,
  input  logic                          PWRITE,
  input  logic [cpuPkg::APB_ADDR_W-1:0] PADDR,
  input  logic [15:0]                   PWDATA,
  output logic [15:0]                   PRDATA,
  output logic                          PREADY,
  output logic                          PSLVERR,
  input  logic                          running,
  output logic                          start,
  output logic                          imWe,
  output logic [cpuPkg::APB_ADDR_W-3:0] imAddr,
  output cpuPkg::instrT                 imWdata,
  input  cpuPkg::dmReqT                 coreDmReq,
  output cpuPkg::dmReqT                 dmReq,
  input  cpuPkg::dataT                  dmRdata
);
  import cpuPkg::*;

  localparam logic [1:0] RGN_IM   = 2'b00;
  localparam logic [1:0] RGN_DM   = 2'b01;
  localparam logic [1:0] RGN_CTRL = 2'b10;

  logic  access;
  logic  rgnIm;
  logic  rgnDm;
  logic  rgnCtrl;
  logic  slvErr;
  logic  dmRead;
  logic  rdWait;
  dmReqT hostReq;

  assign access  = PSEL && PENABLE;
  assign rgnIm   = (PADDR[APB_ADDR_W-1 -: 2] == RGN_IM);
  assign rgnDm   = (PADDR[APB_ADDR_W-1 -: 2] == RGN_DM);
  assign rgnCtrl = (PADDR[APB_ADDR_W-1 -: 2] == RGN_CTRL);

  // memories belong to the core while it runs
  assign slvErr = (rgnIm && (!PWRITE || running)) || (rgnDm && running)
                  || !(rgnIm || rgnDm || rgnCtrl);
  assign dmRead = rgnDm && !PWRITE && !slvErr;

  // registered memory read costs one wait state
  always_ff @(posedge clk)
  begin
    if (RESET)
      rdWait <= 1'b0;
    else
      rdWait <= access && dmRead && !rdWait;
  end

  assign PREADY  = access && (!dmRead || rdWait);
  assign PSLVERR = PREADY && slvErr;

  always_comb
  begin
    if (rgnCtrl)
      PRDATA = {15'd0, running};
    else if (dmRead)
      PRDATA = {8'd0, dmRdata};
    else
      PRDATA = '0;
  end

  assign start   = access && rgnCtrl && PWRITE && PWDATA[0] && !running;
  assign imWe    = access && rgnIm && PWRITE && !slvErr;
  assign imAddr  = PADDR[APB_ADDR_W-3:0];
  assign imWdata = PWDATA;

  always_comb
  begin
    hostReq                    = '0;
    hostReq.en                 = access && rgnDm && !slvErr && (PWRITE || !rdWait);
    hostReq.we                 = PWRITE;
    hostReq.addr[dmAddrW-1:0]  = PADDR[dmAddrW-1:0];
    hostReq.wdata              = PWDATA[7:0];
  end

  assign dmReq = running ? coreDmReq : hostReq;

  // access phase always follows a setup phase
  assert property (@(posedge clk) disable iff (RESET) PENABLE |-> $past(PSEL));

endmodule

/* hw/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
  parameter int imAddrW = 8
) (
  input  logic               clk,
  input  logic               RESET,
  input  logic               clear,
  input  logic               inc,
  input  logic               load,
  input  cpuPkg::instrT      target,
  output logic [imAddrW-1:0] pc
);

  always_ff @(posedge clk)
  begin
    if (RESET || clear)
      pc <= '0;
    else if (load)
      pc <= target[imAddrW-1:0];
    else if (inc)
      pc <= pc + 1'b1;
  end

  // the sequencer picks either the branch target or the skip
  assert property (@(posedge clk) disable iff (RESET) !(inc && load));

endmodule

/* hw/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
  input  logic           clk,
  input  logic           RESET,
  input  logic           we,
  input  cpuPkg::regIdxT wIdx,
  input  cpuPkg::dataT   wData,
  input  cpuPkg::regIdxT rIdx,
  output cpuPkg::dataT   rData
);
  import cpuPkg::*;

  dataT regs [8];

  always_ff @(posedge clk)
  begin
    if (RESET)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (we)
    begin
      regs[wIdx] <= wData;
    end
  end

  // read port is combinational
  assign rData = regs[rIdx];

endmodule

/* hw/sequencer.sv */
`timescale 1ns/1ps

module sequencer (
  input  logic            clk,
  input  logic            RESET,
  input  logic            start,
  output logic            running,
  input  cpuPkg::instrT   instr,
  input  cpuPkg::flagsT   flags,
  input  cpuPkg::dataT    acc,
  output logic            fetch,
  output logic            pcInc,
  output logic            pcLoad,
  output cpuPkg::aluCtrlT aluCtrl,
  output cpuPkg::dataT    loadData,
  output logic            regWrite,
  output cpuPkg::regIdxT  regIdx,
  output cpuPkg::dmReqT   dmReq,
  input  cpuPkg::dataT    dmRdata
);
  import cpuPkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEMWAIT,
    ST_BRTGT
  } stateT;

  stateT      state;
  stateT      nextState;
  instrClassT cls;
  logic [2:0] op3;
  logic [2:0] brCond;
  logic       taken;

  assign cls     = instrClassT'(instr[15:14]);
  assign op3     = instr[13:11];
  assign running = (state != ST_IDLE);

  always_ff @(posedge clk)
  begin
    if (RESET)
      state <= ST_IDLE;
    else
      state <= nextState;
  end

  // condition is needed once the target word replaces the branch word
  always_ff @(posedge clk)
  begin
    if (state == ST_EXEC && cls == CLS_BR)
      brCond <= op3;
  end

  always_comb
  begin
    case (brCond)
      BR_ALWAYS: taken = 1'b1;
      BR_Z:      taken = flags.z;
      BR_C:      taken = flags.c;
      BR_B:      taken = flags.b;
      BR_P:      taken = flags.p;
      default:   taken = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state machine and decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    nextState = state;
    fetch     = 1'b0;
    pcInc     = 1'b0;
    pcLoad    = 1'b0;
    aluCtrl   = '{op: OP_NONE, func: 3'd0};
    loadData  = instr[7:0];
    regWrite  = 1'b0;
    regIdx    = instr[10:8];
    dmReq     = '0;
    case (state)
      ST_IDLE:
      begin
        if (start)
          nextState = ST_FETCH;
      end
      ST_FETCH:
      begin
        fetch     = 1'b1;
        pcInc     = 1'b1;
        nextState = ST_EXEC;
      end
      ST_EXEC:
      begin
        nextState = ST_FETCH;
        case (cls)
          CLS_DT:
          begin
            case (op3)
              DT_MOV_RA: aluCtrl  = '{op: OP_LOAD, func: LD_SRC_REG};
              DT_LDI:    aluCtrl  = '{op: OP_LOAD, func: LD_SRC_BUS};
              DT_MOV_AR: regWrite = 1'b1;
              DT_LDM:
              begin
                dmReq     = '{en: 1'b1, we: 1'b0, addr: instr[7:0], wdata: acc};
                nextState = ST_MEMWAIT;
              end
              DT_STM:    dmReq    = '{en: 1'b1, we: 1'b1, addr: instr[7:0], wdata: acc};
              default:   ;
            endcase
          end
          CLS_ALU:
          begin
            // second operand register sits lower in alu words
            regIdx = instr[8:6];
            if (instr[13:12] == ALU_GRP_TWO)
              aluCtrl = '{op: OP_TWO, func: instr[11:9]};
            else if (instr[13:12] == ALU_GRP_ONE)
              aluCtrl = '{op: OP_ONE, func: instr[11:9]};
          end
          CLS_BR:
          begin
            // read the target word at the already advanced pc
            fetch     = 1'b1;
            nextState = ST_BRTGT;
          end
          CLS_MIO:
          begin
            case (op3)
              MIO_HALT: nextState = ST_IDLE;
              MIO_IN:   aluCtrl   = '{op: OP_IN, func: 3'd0};
              MIO_OUT:  aluCtrl   = '{op: OP_OUT, func: 3'd0};
              default:  ;
            endcase
          end
        endcase
      end
      ST_MEMWAIT:
      begin
        aluCtrl   = '{op: OP_LOAD, func: LD_SRC_BUS};
        loadData  = dmRdata;
        nextState = ST_FETCH;
      end
      ST_BRTGT:
      begin
        // untaken branch steps over the target word
        pcLoad    = taken;
        pcInc     = !taken;
        nextState = ST_FETCH;
      end
      default: nextState = ST_IDLE;
    endcase
  end

  // no register or memory writes while the core is stopped
  assert property (@(posedge clk) disable iff (RESET)
    (state == ST_IDLE) |-> !(regWrite || dmReq.en));

endmodule

/* hw/wordMemory.sv */
`timescale 1ns/1ps

module wordMemory #(
  parameter type wordT = logic [7:0],
  parameter int  addrW = 8
) (
  input  logic             clk,
  input  logic             en,
  input  logic             we,
  input  logic [addrW-1:0] addr,
  input  wordT             wdata,
  output wordT             rdata
);

  localparam int DEPTH = 1 << addrW;

  wordT mem [DEPTH];

  // read data holds until the next enabled read
  always_ff @(posedge clk)
  begin
    if (en)
    begin
      if (we)
        mem[addr] <= wdata;
      else
        rdata <= mem[addr];
    end
  end

  assert property (@(posedge clk) en |-> !$isunknown(addr) && (int'(addr) < DEPTH));

endmodule

/* verif/tbPrograms.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// flags kept in z, c, b, p order
typedef struct packed {
  logic z;
  logic c;
  logic b;
  logic p;
} refFlagsT;

typedef struct packed {
  refFlagsT   flags;
  logic [7:0] value;
} refResultT;

// machine class with an unused op field
localparam logic [15:0] nopWord = 16'hffff;

////////////////////////////////////////////////////////////////////////////
// instruction words
////////////////////////////////////////////////////////////////////////////

function automatic logic [15:0] encLdi(input logic [7:0] imm);
  return {5'b00001, 3'b000, imm};
endfunction

function automatic logic [15:0] encMovFromAcc(input logic [2:0] r);
  return {5'b00010, r, 8'h00};
endfunction

function automatic logic [15:0] encStoreMem(input logic [7:0] addr);
  return {5'b00101, 3'b000, addr};
endfunction

function automatic logic [15:0] encTwoOp(input logic [2:0] fn, input logic [2:0] r);
  return {4'b0100, fn, r, 6'd0};
endfunction

function automatic logic [15:0] encOneOp(input logic [2:0] fn);
  return {4'b0101, fn, 9'd0};
endfunction

// the target word follows this one
function automatic logic [15:0] encBranch(input logic [2:0] cond);
  return {2'b10, cond, 11'd0};
endfunction

function automatic logic [15:0] encHalt();
  return {5'b11000, 11'd0};
endfunction

function automatic logic [15:0] encIn();
  return {5'b11100, 11'd0};
endfunction

function automatic logic [15:0] encOut();
  return {5'b11101, 11'd0};
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////////////////////

// and, xor, or, add, sub
function automatic refResultT twoOpModel(input logic [2:0] fn, input logic [7:0] a,
                                         input logic [7:0] b, input refFlagsT fin);
  refResultT r;
  r.flags = fin;
  case (fn)
    3'd0: r.value = a & b;
    3'd1: r.value = a ^ b;
    3'd2: r.value = a | b;
    3'd3:
    begin
      r.value   = a + b;
      r.flags.c = (int'(a) + int'(b) > 255);
    end
    default:
    begin
      r.value   = a - b;
      r.flags.b = (a < b);
    end
  endcase
  r.flags.z = (r.value == 8'd0);
  r.flags.p = ^r.value;
  return r;
endfunction

// complement, increment, decrement, rotate right, rotate left
function automatic logic [7:0] oneOpModel(input logic [2:0] fn, input logic [7:0] a);
  case (fn)
    3'd0: return ~a;
    3'd1: return a + 8'd1;
    3'd2: return a - 8'd1;
    3'd3: return (a >> 1) | (a << 7);
    default: return (a << 1) | (a >> 7);
  endcase
endfunction

`endif

/* verif/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu;

  `include "tbPrograms.svh"

  localparam int          readyLimit    = 16;
  localparam int          haltPollLimit = 400;
  localparam logic [11:0] ctrlAddr      = 12'h800;

  typedef struct packed {
    logic        valid;
    logic [15:0] got;
    logic [15:0] exp;
  } checkT;

  logic        clk;
  logic        RESET;
  logic [7:0]  inPort;
  logic [7:0]  outPort;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [11:0] PADDR;
  logic [15:0] PWDATA;
  logic [15:0] PRDATA;
  logic        PREADY;
  logic        PSLVERR;

  checkT       chk;
  string       chkName;
  int          checkCount = 0;
  int          errorCount = 0;
  int          timeoutCount = 0;
  logic [15:0] prog [$];
  refFlagsT    flagModel;

  cpuTop #(.imAddrW(8), .dmAddrW(8)) u_cpuTop (
    .clk     (clk),
    .RESET   (RESET),
    .inPort  (inPort),
    .outPort (outPort),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////////////////////

  // posted value compare held across one rising edge
  assert property (@(posedge clk) chk.valid |-> (chk.got == chk.exp))
  else
  begin
    errorCount++;
    $display("Fail %0t ns: %s got %h, expected %h", $time, chkName, chk.got, chk.exp);
  end

  assert property (@(posedge clk) disable iff (RESET)
    !(PSEL && PENABLE) |-> !(PREADY || PSLVERR))
  else
  begin
    errorCount++;
    $display("PREADY or PSLVERR went high outside an APB access at %0t ns", $time);
  end

  function automatic logic [11:0] dmAddr(input int offset);
    return {4'b0100, offset[7:0]};
  endfunction

  task automatic finishRun();
    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  endtask

  task automatic expectValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    @(negedge clk);
    chkName = name;
    chk     = '{valid: 1'b1, got: got, exp: exp};
    checkCount++;
    @(negedge clk);
    chk.valid = 1'b0;
  endtask

  // one APB transfer with waits counting the cycles of PREADY low
  task automatic apbXfer(input logic write, input logic [11:0] addr,
                         input logic [15:0] wdata, output logic [15:0] rdata,
                         output logic err, output int waits);
    @(negedge clk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = write;
    PADDR   = addr;
    PWDATA  = wdata;
    @(negedge clk);
    PENABLE = 1'b1;
    waits   = 0;
    #1;
    while (!PREADY && waits < readyLimit)
    begin
      @(negedge clk);
      #1;
      waits++;
    end
    rdata = PRDATA;
    err   = PSLVERR;
    if (!PREADY)
    begin
      timeoutCount++;
      $display("no PREADY from address %h within %0d cycles", addr, readyLimit);
      finishRun();
    end
    else
    begin
      @(negedge clk);
      PSEL    = 1'b0;
      PENABLE = 1'b0;
    end
  endtask

  task automatic loadProgram();
    logic [15:0] rd;
    logic        err;
    int          waits;
    for (int i = 0; i < prog.size(); i++)
      apbXfer(1'b1, {2'b00, i[9:0]}, prog[i], rd, err, waits);
  endtask

  task automatic startCore();
    logic [15:0] rd;
    logic        err;
    int          waits;
    apbXfer(1'b1, ctrlAddr, 16'h0001, rd, err, waits);
  endtask

  task automatic waitHalt();
    logic [15:0] rd;
    logic        err;
    int          waits;
    int          polls;
    polls = 0;
    rd    = 16'h0001;
    while (rd[0] && polls < haltPollLimit)
    begin
      apbXfer(1'b0, ctrlAddr, 16'h0000, rd, err, waits);
      polls++;
    end
    if (rd[0])
    begin
      timeoutCount++;
      $display("core still running after %0d control register reads", polls);
      finishRun();
    end
  endtask

  task automatic runProgram();
    loadProgram();
    startCore();
    waitHalt();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [15:0] rd;
    logic        err;
    int          waits;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [7:0]  byteVal;
    logic [2:0]  fn3;
    logic        setIt;
    logic        taken;
    refResultT   res;
    logic [7:0]  twoExp [5];
    logic [7:0]  oneExp [5];
    logic [7:0]  markExp [8];
    void'($urandom(32'h7a29_798e));
    RESET     = 1'b1;
    PSEL      = 1'b0;
    PENABLE   = 1'b0;
    PWRITE    = 1'b0;
    PADDR     = '0;
    PWDATA    = '0;
    inPort    = '0;
    chk       = '0;
    flagModel = '0;
    repeat (4) @(negedge clk);
    RESET = 1'b0;

    // host access while halted
    byteVal = 8'($urandom());
    apbXfer(1'b1, dmAddr(16), {8'h00, byteVal}, rd, err, waits);
    expectValue("dm write error", {15'd0, err}, 16'd0);
    expectValue("dm write wait states", 16'(waits), 16'd0);
    apbXfer(1'b0, dmAddr(16), 16'h0000, rd, err, waits);
    expectValue("dm read data", rd, {8'h00, byteVal});
    expectValue("dm read wait states", 16'(waits), 16'd1);
    apbXfer(1'b0, 12'h005, 16'h0000, rd, err, waits);
    expectValue("im read error", {15'd0, err}, 16'd1);

    // host access while a long nop program runs
    prog.delete();
    for (int i = 0; i < 40; i++)
      prog.push_back(nopWord);
    prog.push_back(encHalt());
    loadProgram();
    startCore();
    apbXfer(1'b0, ctrlAddr, 16'h0000, rd, err, waits);
    expectValue("running after start", {15'd0, rd[0]}, 16'd1);
    apbXfer(1'b1, dmAddr(16), {8'h00, ~byteVal}, rd, err, waits);
    expectValue("dm write while running error", {15'd0, err}, 16'd1);
    apbXfer(1'b0, dmAddr(16), 16'h0000, rd, err, waits);
    expectValue("dm read while running error", {15'd0, err}, 16'd1);
    apbXfer(1'b1, 12'h000, nopWord, rd, err, waits);
    expectValue("im write while running error", {15'd0, err}, 16'd1);
    waitHalt();
    apbXfer(1'b0, dmAddr(16), 16'h0000, rd, err, waits);
    expectValue("dm byte after rejected write", rd, {8'h00, byteVal});

    // two-operand ops with the second operand in register n+1
    prog.delete();
    for (int fn = 0; fn < 5; fn++)
    begin
      a   = 8'($urandom());
      b   = 8'($urandom());
      res = twoOpModel(3'(fn), a, b, flagModel);
      flagModel  = res.flags;
      twoExp[fn] = res.value;
      prog.push_back(encLdi(b));
      prog.push_back(encMovFromAcc(3'(fn + 1)));
      prog.push_back(encLdi(a));
      prog.push_back(encTwoOp(3'(fn), 3'(fn + 1)));
      prog.push_back(encStoreMem(8'h20 + 8'(fn)));
    end
    prog.push_back(encHalt());
    runProgram();
    for (int fn = 0; fn < 5; fn++)
    begin
      apbXfer(1'b0, dmAddr(32 + fn), 16'h0000, rd, err, waits);
      expectValue($sformatf("two-operand op %0d", fn), rd, {8'h00, twoExp[fn]});
    end

    // single-operand ops
    prog.delete();
    for (int fn = 0; fn < 5; fn++)
    begin
      a          = 8'($urandom());
      oneExp[fn] = oneOpModel(3'(fn), a);
      prog.push_back(encLdi(a));
      prog.push_back(encOneOp(3'(fn)));
      prog.push_back(encStoreMem(8'h30 + 8'(fn)));
    end
    prog.push_back(encHalt());
    runProgram();
    for (int fn = 0; fn < 5; fn++)
    begin
      apbXfer(1'b0, dmAddr(48 + fn), 16'h0000, rd, err, waits);
      expectValue($sformatf("single-operand op %0d", fn), rd, {8'h00, oneExp[fn]});
    end

    // branch on z, c, b, p with the flag first set, then cleared
    prog.delete();
    for (int i = 0; i < 8; i++)
    begin
      setIt = (i % 2 == 0);
      case (i / 2)
        0:
        begin
          fn3 = 3'd1;
          a   = 8'($urandom());
          b   = setIt ? a : (a ^ 8'h3c);
        end
        1:
        begin
          fn3 = 3'd3;
          a   = setIt ? (8'($urandom()) | 8'h80) : (8'($urandom()) & 8'h7f);
          b   = setIt ? (8'($urandom()) | 8'h80) : (8'($urandom()) & 8'h3f);
        end
        2:
        begin
          fn3 = 3'd4;
          a   = 8'($urandom()) & 8'h7f;
          b   = setIt ? (a | 8'h80) : (a & 8'h3f);
        end
        default:
        begin
          fn3 = 3'd1;
          a   = 8'($urandom());
          b   = 8'h00;
          if ((^a) != setIt)
            a = a ^ 8'h01;
        end
      endcase
      res       = twoOpModel(fn3, a, b, flagModel);
      flagModel = res.flags;
      case (i / 2)
        0: taken = res.flags.z;
        1: taken = res.flags.c;
        2: taken = res.flags.b;
        default: taken = res.flags.p;
      endcase
      markExp[i] = taken ? 8'haa : 8'h55;
      prog.push_back(encLdi(b));
      prog.push_back(encMovFromAcc(3'd1));
      prog.push_back(encLdi(a));
      prog.push_back(encTwoOp(fn3, 3'd1));
      prog.push_back(encLdi(8'haa));
      prog.push_back(encStoreMem(8'h40 + 8'(i)));
      prog.push_back(encBranch(3'(i / 2 + 1)));
      // target lands just past the untaken marker store
      prog.push_back(16'(prog.size() + 3));
      prog.push_back(encLdi(8'h55));
      prog.push_back(encStoreMem(8'h40 + 8'(i)));
    end
    prog.push_back(encHalt());
    runProgram();
    for (int i = 0; i < 8; i++)
    begin
      apbXfer(1'b0, dmAddr(64 + i), 16'h0000, rd, err, waits);
      expectValue($sformatf("branch marker %0d", i), rd, {8'h00, markExp[i]});
    end

    // input port through to output port
    byteVal = 8'($urandom());
    @(negedge clk);
    inPort = byteVal;
    prog.delete();
    prog.push_back(encIn());
    prog.push_back(encOut());
    prog.push_back(encHalt());
    runProgram();
    expectValue("output port", {8'h00, outPort}, {8'h00, byteVal});

    finishRun();
  end

endmodule
